// File: verilog.f
hw/vgaPkg.sv
hw/vgaTiming.sv
hw/vgaRegs.sv
hw/vgaPixelGen.sv
hw/vgaOutput.sv
hw/vgaTop.sv
testbench/vgaTb_assertions.sv
testbench/vgaTb.sv

// File: run.sh
#!/bin/sh
rm -f sim.log \
	&& verilator --binary --timing --assert --timescale 1ns/1ns --top-module vgaTb \
		-f verilog.f -o vgaSim \
	&& ./obj_dir/vgaSim +verilator+error+limit+1000 > sim.log 2>&1 \
	|| echo "build or simulation exited with an error" >> sim.log
cat sim.log
grep -q "tests failed" sim.log && exit 1
grep -q "all tests passed" sim.log || exit 1
exit 0

// File: testbench/vgaTb.sv
`timescale 1ns/1ns
`default_nettype none

module vgaTb;

	import vgaPkg::*;

	localparam integer hActive = 16;
	localparam integer hFront = 2;
	localparam integer hSyncLen = 3;
	localparam integer hBack = 3;
	localparam integer vActive = 8;
	localparam integer vFront = 1;
	localparam integer vSyncLen = 2;
	localparam integer vBack = 2;
	localparam integer hTotal = hActive + hFront + hSyncLen + hBack;
	localparam integer vTotal = vActive + vFront + vSyncLen + vBack;
	localparam integer frameCycles = hTotal * vTotal;
	localparam integer period = 40;
	// Twelve frames plus the register traffic
	localparam integer limitCycles = 12 * frameCycles + 400;

	logic clk;
	logic rst;
	logic cyc;
	logic stb;
	logic we;
	wbAddr_t adr;
	wbData_t datIn;
	wbData_t datOut;
	logic ack;
	logic hSync;
	logic vSync;
	color_t rgb;

	integer seed = 74;
	int errors;
	logic wroteOnce;
	logic checkPixels;
	drawCfg_t model;

	// Beam position rebuilt from the sync pins
	int x;
	int y;
	logic hKnown;
	logic vKnown;
	logic hPrev;
	logic vPrev;
	int hRun;
	int vRun;
	int hHigh;
	int vHigh;

	vgaTop #(
		.hActive(hActive),
		.hFront(hFront),
		.hSyncLen(hSyncLen),
		.hBack(hBack),
		.vActive(vActive),
		.vFront(vFront),
		.vSyncLen(vSyncLen),
		.vBack(vBack)
	) dut (
		.clk(clk),
		.rst(rst),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datIn(datIn),
		.datOut(datOut),
		.ack(ack),
		.hSync(hSync),
		.vSync(vSync),
		.rgb(rgb)
	);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	task automatic valueError(input string name, input int expected, input int actual);
		errors++;
		$display("Error %s: expected %0h, got %0h", name, expected, actual);
	endtask

	function automatic color_t expectedColor(input int px, input int py);
		logic inBox;
		inBox = px >= int'(model.boxX0) && px <= int'(model.boxX1)
			&& py >= int'(model.boxY0) && py <= int'(model.boxY1);
		if (!model.enable || px >= hActive || py >= vActive) begin
			return '0;
		end
		return inBox ? model.fgColor : model.bgColor;
	endfunction

	task automatic busAccess(input logic write, input wbAddr_t addr, input wbData_t data,
		output wbData_t rdata);
		int waited;
		@(posedge clk);
		#5;
		cyc = 1'b1;
		stb = 1'b1;
		we = write;
		adr = addr;
		datIn = data;
		if (write) begin
			wroteOnce = 1'b1;
		end
		waited = 0;
		do begin
			@(posedge clk);
			#5;
			waited++;
		end while (!ack && waited < 8);
		assert (ack) else begin
			errors++;
			$display("Bus access to address %0d was never acknowledged", addr);
		end
		rdata = datOut;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	// Program one drawing setup, skip to a frame start, then check a whole frame
	task automatic checkFrame(input drawCfg_t c);
		wbData_t unused;
		checkPixels = 1'b0;
		busAccess(1'b1, regBoxX, {6'b0, c.boxX1, 6'b0, c.boxX0}, unused);
		busAccess(1'b1, regBoxY, {6'b0, c.boxY1, 6'b0, c.boxY0}, unused);
		busAccess(1'b1, regCtrl, {25'b0, c.fgColor, c.bgColor, c.enable}, unused);
		model = c;
		@(posedge vSync);
		checkPixels = 1'b1;
		@(posedge vSync);
		checkPixels = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// Pin monitor sampled on the falling edge
	////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		string name;
		if (!wroteOnce) begin
			assert ({hSync, vSync, rgb, ack} == 6'b0)
				else valueError("reset outputs", 0, int'({hSync, vSync, rgb, ack}));
		end
		if (rst) begin
			hKnown = 1'b0;
			vKnown = 1'b0;
			hRun = 0;
			vRun = 0;
			hHigh = 0;
			vHigh = 0;
		end else begin
			hRun = hRun + 1;
			vRun = vRun + 1;
			x = (x + 1) % hTotal;
			if (x == 0 && vKnown) begin
				y = (y + 1) % vTotal;
			end
			// Sync rise marks the first retrace position
			if (hSync && !hPrev) begin
				if (hKnown) begin
					assert (hRun == hTotal) else valueError("hSync period", hTotal, hRun);
				end
				hRun = 0;
				x = hActive + hFront;
				hKnown = 1'b1;
			end
			if (!hSync && hPrev) begin
				assert (hHigh == hSyncLen) else valueError("hSync width", hSyncLen, hHigh);
			end
			hHigh = hSync ? hHigh + 1 : 0;
			if (vSync && !vPrev) begin
				if (vKnown) begin
					assert (vRun == frameCycles)
						else valueError("vSync period", frameCycles, vRun);
				end
				vRun = 0;
				y = vActive + vFront;
				vKnown = 1'b1;
			end
			if (!vSync && vPrev) begin
				assert (vHigh == hTotal * vSyncLen)
					else valueError("vSync width", hTotal * vSyncLen, vHigh);
			end
			vHigh = vSync ? vHigh + 1 : 0;
			if (checkPixels && hKnown && vKnown) begin
				if (x < hActive && y < vActive) begin
					name = "draw";
				end else begin
					name = "blank";
				end
				assert (rgb == expectedColor(x, y))
					else valueError($sformatf("%s x=%0d y=%0d", name, x, y),
						int'(expectedColor(x, y)), int'(rgb));
			end
		end
		hPrev = hSync;
		vPrev = vSync;
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	initial begin
		int a;
		int p;
		int q;
		int n;
		wbData_t w;
		wbData_t got;
		wbData_t want;
		drawCfg_t c;
		rst = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		datIn = '0;
		errors = 0;
		wroteOnce = 1'b0;
		checkPixels = 1'b0;
		model = '0;
		x = 0;
		y = 0;
		repeat (8) @(posedge clk);
		#5;
		rst = 1'b0;

		// Write then read back every word address
		for (a = 0; a < 4; a++) begin
			w = $random(seed);
			busAccess(1'b1, wbAddr_t'(a), w, got);
			busAccess(1'b0, wbAddr_t'(a), '0, got);
			case (a)
				0: want = w & 32'h0000007F;
				1, 2: want = w & 32'h03FF03FF;
				default: want = '0;
			endcase
			assert (got == want)
				else valueError($sformatf("register %0d", a), int'(want), int'(got));
		end

		// Drawing off with colors set so nothing may reach the pins
		c = '0;
		c.bgColor = 3'b101;
		c.fgColor = 3'b011;
		c.boxX1 = 10'd15;
		c.boxY1 = 10'd7;
		checkFrame(c);

		for (n = 0; n < 3; n++) begin
			c.enable = 1'b1;
			c.bgColor = color_t'($random(seed) & 7);
			c.fgColor = color_t'($random(seed) & 7);
			p = $random(seed) & 15;
			q = $random(seed) & 15;
			c.boxX0 = coord_t'((p < q) ? p : q);
			c.boxX1 = coord_t'((p < q) ? q : p);
			p = $random(seed) & 7;
			q = $random(seed) & 7;
			c.boxY0 = coord_t'((p < q) ? p : q);
			c.boxY1 = coord_t'((p < q) ? q : p);
			checkFrame(c);
		end

		errors = errors + dut.checks.ackLenFails + dut.checks.ackCauseFails
			+ dut.checks.blankFails;
		$display("Summary: %0d errors", errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	initial begin
		#(limitCycles * period);
		$display("Timeout: the test sequence did not finish within %0d cycles", limitCycles);
		$display("Summary: %0d errors", errors + 1);
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/vgaTb_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module vgaSignalChecks (
	input wire logic clk,
	input wire logic rst,
	input wire logic cyc,
	input wire logic stb,
	input wire logic ack,
	input wire logic hSync,
	input wire logic vSync,
	input wire vgaPkg::color_t rgb
);

	// Failure counts per property
	int ackLenFails = 0;
	int ackCauseFails = 0;
	int blankFails = 0;

	ackOneCycle: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
		else begin
			ackLenFails++;
			$error("ack stayed high for more than one cycle");
		end

	// Slave answers only a request seen on the previous edge
	ackAfterRequest: assert property (@(posedge clk) disable iff (rst)
		ack |-> $past(cyc && stb))
		else begin
			ackCauseFails++;
			$error("ack appeared without a cyc and stb request");
		end

	blankInRetrace: assert property (@(posedge clk) disable iff (rst)
		(hSync || vSync) |-> rgb == '0)
		else begin
			blankFails++;
			$error("rgb was driven during a sync pulse");
		end

endmodule

bind vgaTop vgaSignalChecks checks (
	.clk(clk),
	.rst(rst),
	.cyc(cyc),
	.stb(stb),
	.ack(ack),
	.hSync(hSync),
	.vSync(vSync),
	.rgb(rgb)
);

`default_nettype wire

// File: hw/vgaTop.sv
`timescale 1ns/1ns
`default_nettype none

module vgaTop #(
	parameter integer hActive = 640,
	parameter integer hFront = 16,
	parameter integer hSyncLen = 96,
	parameter integer hBack = 48,
	parameter integer vActive = 480,
	parameter integer vFront = 10,
	parameter integer vSyncLen = 2,
	parameter integer vBack = 33
) (
	input wire logic clk,
	input wire logic rst,
	// Wishbone classic slave
	input wire logic cyc,
	input wire logic stb,
	input wire logic we,
	input vgaPkg::wbAddr_t adr,
	input vgaPkg::wbData_t datIn,
	output vgaPkg::wbData_t datOut,
	output logic ack,
	// Display pins
	output logic hSync,
	output logic vSync,
	output vgaPkg::color_t rgb
);

	import vgaPkg::*;

	beamPos_t beam;
	drawCfg_t cfg;
	pixel_t pixel;

	////////////////////////////////////////////////////////////
	// Raster source
	////////////////////////////////////////////////////////////

	vgaTiming #(
		.hActive(hActive),
		.hFront(hFront),
		.hSyncLen(hSyncLen),
		.hBack(hBack),
		.vActive(vActive),
		.vFront(vFront),
		.vSyncLen(vSyncLen),
		.vBack(vBack)
	) timing (
		.clk(clk),
		.rst(rst),
		.beam(beam)
	);

	////////////////////////////////////////////////////////////
	// Decode, execute, result
	////////////////////////////////////////////////////////////

	vgaRegs regs (
		.clk(clk),
		.rst(rst),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datIn(datIn),
		.datOut(datOut),
		.ack(ack),
		.cfg(cfg)
	);

	vgaPixelGen pixelGen (
		.clk(clk),
		.rst(rst),
		.beam(beam),
		.cfg(cfg),
		.pixel(pixel)
	);

	// Two cycles from beam to pins
	vgaOutput out (
		.clk(clk),
		.rst(rst),
		.pixel(pixel),
		.enable(cfg.enable),
		.hSync(hSync),
		.vSync(vSync),
		.rgb(rgb)
	);

endmodule

`default_nettype wire

// File: hw/vgaOutput.sv
`timescale 1ns/1ns
`default_nettype none

module vgaOutput (
	input wire logic clk,
	input wire logic rst,
	input vgaPkg::pixel_t pixel,
	input wire logic enable,
	output logic hSync,
	output logic vSync,
	output vgaPkg::color_t rgb
);

	logic show;

	// Blank during retrace, porches, or when drawing is off
	assign show = pixel.active && enable;

	always_ff @(posedge clk) begin
		if (rst) begin
			hSync <= 1'b0;
			vSync <= 1'b0;
			rgb <= '0;
		end else begin
			hSync <= pixel.hSync;
			vSync <= pixel.vSync;
			rgb <= show ? pixel.color : '0;
		end
	end

endmodule

`default_nettype wire

// File: hw/vgaPixelGen.sv
`timescale 1ns/1ns
`default_nettype none

module vgaPixelGen (
	input wire logic clk,
	input wire logic rst,
	input vgaPkg::beamPos_t beam,
	input vgaPkg::drawCfg_t cfg,
	output vgaPkg::pixel_t pixel
);

	import vgaPkg::*;

	logic inX;
	logic inY;
	logic hit;
	color_t pick;

	////////////////////////////////////////////////////////////
	// Rectangle hit test
	////////////////////////////////////////////////////////////

	// Corners are inclusive on both axes
	assign inX = (beam.hCount >= cfg.boxX0) && (beam.hCount <= cfg.boxX1);
	assign inY = (beam.vCount >= cfg.boxY0) && (beam.vCount <= cfg.boxY1);
	assign hit = inX && inY;

	assign pick = hit ? cfg.fgColor : cfg.bgColor;

	// Flags ride in the same stage as the color
	always_ff @(posedge clk) begin
		if (rst) begin
			pixel <= '0;
		end else begin
			pixel.color <= pick;
			pixel.active <= beam.active;
			pixel.hSync <= beam.hSync;
			pixel.vSync <= beam.vSync;
		end
	end

endmodule

`default_nettype wire

// File: hw/vgaRegs.sv
`timescale 1ns/1ns
`default_nettype none

module vgaRegs (
	input wire logic clk,
	input wire logic rst,
	input wire logic cyc,
	input wire logic stb,
	input wire logic we,
	input vgaPkg::wbAddr_t adr,
	input vgaPkg::wbData_t datIn,
	output vgaPkg::wbData_t datOut,
	output logic ack,
	output vgaPkg::drawCfg_t cfg
);

	import vgaPkg::*;

	busState_t state;
	wbData_t readWord;
	logic take;

	// New request only counts in idle
	assign take = (state == busIdle) && cyc && stb;
	assign ack = state == busAck;

	////////////////////////////////////////////////////////////
	// Read-back word
	////////////////////////////////////////////////////////////

	always_comb begin
		readWord = '0;
		case (adr)
			regCtrl: begin
				readWord[0] = cfg.enable;
				readWord[3:1] = cfg.bgColor;
				readWord[6:4] = cfg.fgColor;
			end
			regBoxX: begin
				readWord[9:0] = cfg.boxX0;
				readWord[25:16] = cfg.boxX1;
			end
			regBoxY: begin
				readWord[9:0] = cfg.boxY0;
				readWord[25:16] = cfg.boxY1;
			end
			default: readWord = '0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Bus FSM and settings
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= busIdle;
			cfg <= '0;
		end else begin
			case (state)
				busIdle: if (take) state <= busAck;
				busAck: state <= busIdle;
				default: state <= busIdle;
			endcase

			// Write lands on the cycle the request is seen
			if (take && we) begin
				case (adr)
					regCtrl: begin
						cfg.enable <= datIn[0];
						cfg.bgColor <= datIn[3:1];
						cfg.fgColor <= datIn[6:4];
					end
					regBoxX: begin
						cfg.boxX0 <= datIn[9:0];
						cfg.boxX1 <= datIn[25:16];
					end
					regBoxY: begin
						cfg.boxY0 <= datIn[9:0];
						cfg.boxY1 <= datIn[25:16];
					end
					default: ;
				endcase
			end
		end
	end

	// Captured so it is stable while ack is high
	always_ff @(posedge clk) begin
		if (take) begin
			datOut <= readWord;
		end
	end

endmodule

`default_nettype wire

// File: hw/vgaTiming.sv
`timescale 1ns/1ns
`default_nettype none

module vgaTiming #(
	parameter integer hActive = 640,
	parameter integer hFront = 16,
	parameter integer hSyncLen = 96,
	parameter integer hBack = 48,
	parameter integer vActive = 480,
	parameter integer vFront = 10,
	parameter integer vSyncLen = 2,
	parameter integer vBack = 33
) (
	input wire logic clk,
	input wire logic rst,
	output vgaPkg::beamPos_t beam
);

	import vgaPkg::*;

	localparam integer hTotal = hActive + hFront + hSyncLen + hBack;
	localparam integer vTotal = vActive + vFront + vSyncLen + vBack;

	// Retrace windows with both ends inclusive
	localparam integer hSyncStart = hActive + hFront;
	localparam integer hSyncEnd = hSyncStart + hSyncLen - 1;
	localparam integer vSyncStart = vActive + vFront;
	localparam integer vSyncEnd = vSyncStart + vSyncLen - 1;

	coord_t hNext;
	coord_t vNext;
	logic lineEnd;
	logic frameEnd;

	// Flags that belong to a given position
	function automatic beamPos_t beamAt(input coord_t h, input coord_t v);
		beamPos_t b;
		b.hCount = h;
		b.vCount = v;
		b.active = (h < coord_t'(hActive)) && (v < coord_t'(vActive));
		b.hSync = (h >= coord_t'(hSyncStart)) && (h <= coord_t'(hSyncEnd));
		b.vSync = (v >= coord_t'(vSyncStart)) && (v <= coord_t'(vSyncEnd));
		return b;
	endfunction

	assign lineEnd = beam.hCount == coord_t'(hTotal - 1);
	assign frameEnd = beam.vCount == coord_t'(vTotal - 1);

	////////////////////////////////////////////////////////////
	// Counter stepping
	////////////////////////////////////////////////////////////

	always_comb begin
		hNext = beam.hCount + coord_t'(1);
		vNext = beam.vCount;
		if (lineEnd) begin
			hNext = '0;
			// Vertical steps once per line
			vNext = frameEnd ? '0 : beam.vCount + coord_t'(1);
		end
	end

	// Flags are registered with the counters they describe
	always_ff @(posedge clk) begin
		if (rst) begin
			beam <= beamAt('0, '0);
		end else begin
			beam <= beamAt(hNext, vNext);
		end
	end

endmodule

`default_nettype wire

// File: hw/vgaPkg.sv
`default_nettype none

package vgaPkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////

	// Screen coordinate or raster counter
	typedef logic [9:0] coord_t;

	// 3-bit rgb with one bit per gun
	typedef logic [2:0] color_t;

	typedef logic [31:0] wbData_t;
	typedef logic [1:0] wbAddr_t;

	////////////////////////////////////////////////////////////
	// Pipeline records
	////////////////////////////////////////////////////////////

	// One raster slot as produced by the timing generator
	typedef struct packed {
		coord_t hCount;
		coord_t vCount;
		logic active;
		logic hSync;
		logic vSync;
	} beamPos_t;

	// Drawing settings held in the register block
	typedef struct packed {
		logic enable;
		color_t bgColor;
		color_t fgColor;
		coord_t boxX0;
		coord_t boxX1;
		coord_t boxY0;
		coord_t boxY1;
	} drawCfg_t;

	// Selected color with flags delayed to match
	typedef struct packed {
		color_t color;
		logic active;
		logic hSync;
		logic vSync;
	} pixel_t;

	typedef enum logic {
		busIdle,
		busAck
	} busState_t;

	// Word addresses of the register block
	localparam wbAddr_t regCtrl = 2'd0;
	localparam wbAddr_t regBoxX = 2'd1;
	localparam wbAddr_t regBoxY = 2'd2;

endpackage

`default_nettype wire
